/* lc3b_front_end.f */
+incdir+include
logic/lc3b_types.sv
logic/lc3b_id_if.sv
logic/lc3b_fetch.sv
logic/lc3b_control_rom.sv
logic/ifid.sv
logic/lc3b_regfile.sv
logic/lc3b_front_end.sv
sim/lc3b_front_end_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= lc3b_front_end_tb
FILELIST  ?= lc3b_front_end.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(wildcard include/*.svh logic/*.sv sim/*.sv)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: compile run clean

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BINARY)
	./$(BINARY) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/lc3b_front_end_tb.sv */
`timescale 1ns/1ps
`include "lc3b_cfg.svh"

module lc3b_front_end_tb;

    import lc3b_types::*;

    localparam int RESET_CYCLES = 16;
    // six tests of up to 40 instructions at up to 8 cycles each
    localparam int CYCLE_LIMIT = 6 * 40 * 8 + RESET_CYCLES;

    logic             clk;
    logic             arst_n;
    lc3b_word         imem_addr;
    logic             imem_read;
    lc3b_word         imem_rdata;
    logic             imem_resp;
    logic             advance;
    logic             ready;
    lc3b_word         id_pc;
    lc3b_word         id_imm5;
    lc3b_word         id_offset6;
    lc3b_word         id_offset9;
    lc3b_word         sr1_data;
    lc3b_word         sr2_data;
    lc3b_control_word id_ctrl;
    lc3b_reg          id_dest;
    lc3b_offset11     id_offset11;
    logic             wb_we;
    lc3b_reg          wb_dest;
    lc3b_word         wb_data;

    // instruction memory indexed by word address
    lc3b_word mem [256];
    // what the register file should hold
    lc3b_word reg_model [`LC3B_NUM_REGS];
    // address the next advance should take
    lc3b_word exp_pc;
    integer   seed;
    int       mem_wait;
    int       cycles = 0;
    int       resp_seen = 0;
    int       resp_base;
    int       errors = 0;
    int       test_errors;
    int       checks = 0;
    int       tests = 0;
    string    test_name;

    lc3b_front_end dut (.*);

    always #4 clk = ~clk;

    // run length guard
    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("Timeout: run still going after %0d cycles", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    // responses the front end has taken
    always @(posedge clk)
    begin
        if (imem_resp)
            resp_seen <= resp_seen + 1;
    end

    // memory model answering each request 0 to 3 cycles later with a one-cycle pulse
    always @(negedge clk)
    begin
        imem_resp = 1'b0;
        if (arst_n && imem_read)
        begin
            if (mem_wait == 0)
            begin
                imem_resp  = 1'b1;
                imem_rdata = mem[imem_addr[8:1]];
                mem_wait   = $random(seed) & 3;
            end
            else
                mem_wait = mem_wait - 1;
        end
    end

    task automatic check_word(input string what, input lc3b_word exp, input lc3b_word act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            test_errors++;
            $display("Error: %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_reg(input string what, input lc3b_reg exp, input lc3b_reg act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            test_errors++;
            $display("Error: %s %s: expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic check_ctrl(input string what, input lc3b_control_word exp,
                              input lc3b_control_word act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            test_errors++;
            $display("Error: %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            test_errors++;
            $display("Error: %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    function automatic lc3b_word sext(input lc3b_word v, input int bits);
        lc3b_word r;
        r = v;
        for (int i = bits; i < `LC3B_WORD_W; i++)
            r[i] = v[bits - 1];
        return r;
    endfunction

    // control word table per opcode
    function automatic lc3b_control_word expected_ctrl(input lc3b_word w);
        lc3b_control_word c;
        lc3b_opcode       op;
        op = lc3b_opcode'(w[15:12]);
        c = '0;
        c.opcode       = op;
        c.load_regfile = op inside {op_add, op_and, op_not, op_shf, op_lea,
                                    op_ldb, op_ldi, op_ldr};
        c.mem_read     = op inside {op_ldb, op_ldi, op_ldr};
        c.mem_write    = op inside {op_stb, op_sti, op_str};
        // imm flag only matters for add and and
        c.sr2_sel      = (op inside {op_add, op_and}) && w[5];
        c.branch       = op inside {op_br, op_jmp};
        c.jsr_link     = (op == op_jsr);
        case (op)
            op_add, op_ldb, op_ldi, op_ldr, op_stb, op_sti, op_str: c.aluop = alu_add;
            op_and: c.aluop = alu_and;
            op_not: c.aluop = alu_not;
            // bit 4 picks direction and bit 5 arithmetic
            op_shf: c.aluop = !w[4] ? alu_sll : (w[5] ? alu_sra : alu_srl);
            default: c.aluop = alu_pass;
        endcase
        return c;
    endfunction

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        tests++;
    endtask

    task automatic end_test();
        $display("test %-14s %s, %0d errors", test_name,
                 (test_errors == 0) ? "ok" : "FAILED", test_errors);
    endtask

    // hands the buffered word to IF/ID and returns it with its address
    task automatic advance_one(output lc3b_word w, output lc3b_word pc);
        while (ready !== 1'b1)
            @(negedge clk);
        check_word("fetch address", exp_pc, imem_addr);
        pc = exp_pc;
        w  = mem[exp_pc[8:1]];
        advance = 1'b1;
        @(negedge clk);
        advance   = 1'b0;
        resp_base = resp_seen;
        exp_pc    = exp_pc + lc3b_word'(2);
        // idle cycle while the pc steps
        check_bit("imem_read after advance", 1'b0, imem_read);
        check_bit("ready after advance", 1'b0, ready);
        check_word("next address", exp_pc, imem_addr);
    endtask

    task automatic check_decoded(input lc3b_word w, input lc3b_word pc);
        check_word("id_pc", pc, id_pc);
        check_ctrl("id_ctrl", expected_ctrl(w), id_ctrl);
        check_reg("id_dest", w[11:9], id_dest);
        check_word("id_imm5", sext(w, 5), id_imm5);
        check_word("id_offset6", sext(w, 6), id_offset6);
        check_word("id_offset9", sext(w, 9), id_offset9);
        check_word("id_offset11", lc3b_word'(w[10:0]), lc3b_word'(id_offset11));
        // source indices seen as the registers they select
        check_word("sr1_data", reg_model[w[8:6]], sr1_data);
        check_word("sr2_data", reg_model[w[2:0]], sr2_data);
    endtask

    // program goes after the current word, which is consumed unchecked
    task automatic place_program(input lc3b_word prog[$]);
        lc3b_word w;
        lc3b_word pc;
        foreach (prog[k])
            mem[exp_pc[8:1] + 8'(k + 1)] = prog[k];
        advance_one(w, pc);
    endtask

    task automatic test_reset();
        start_test("reset");
        repeat (RESET_CYCLES)
        begin
            @(negedge clk);
            check_bit("ready in reset", 1'b0, ready);
            check_bit("imem_read in reset", 1'b0, imem_read);
        end
        arst_n = 1'b1;
        @(negedge clk);
        check_bit("imem_read after reset", 1'b1, imem_read);
        check_bit("ready before response", 1'b0, ready);
        check_word("first address", `LC3B_RESET_PC, imem_addr);
        end_test();
    endtask

    task automatic test_regfile();
        lc3b_word w;
        lc3b_word pc;
        lc3b_word prog[$];
        start_test("register file");
        for (int r = 0; r < `LC3B_NUM_REGS; r++)
        begin
            reg_model[r] = lc3b_word'($random(seed));
            wb_we   = 1'b1;
            wb_dest = lc3b_reg'(r);
            wb_data = reg_model[r];
            @(negedge clk);
        end
        wb_we = 1'b0;
        // add with src1 = r and src2 = 7 - r
        for (int r = 0; r < `LC3B_NUM_REGS; r++)
            prog.push_back({4'h1, 3'd0, 3'(r), 3'd0, 3'(7 - r)});
        place_program(prog);
        foreach (prog[k])
        begin
            advance_one(w, pc);
            check_decoded(w, pc);
        end
        // write under a held instruction is seen one cycle later
        reg_model[w[8:6]] = ~reg_model[w[8:6]];
        wb_we   = 1'b1;
        wb_dest = w[8:6];
        wb_data = reg_model[w[8:6]];
        @(negedge clk);
        wb_we = 1'b0;
        check_word("sr1_data after write", reg_model[w[8:6]], sr1_data);
        end_test();
    endtask

    task automatic test_fields();
        lc3b_word w;
        lc3b_word pc;
        start_test("fields");
        repeat (40)
        begin
            advance_one(w, pc);
            check_decoded(w, pc);
        end
        end_test();
    endtask

    task automatic test_decode();
        lc3b_word w;
        lc3b_word pc;
        lc3b_word prog[$];
        start_test("decode");
        // every opcode with the imm flag clear and set
        for (int k = 0; k < 32; k++)
        begin
            w        = lc3b_word'($random(seed));
            w[15:12] = 4'(k / 2);
            w[5]     = k[0];
            prog.push_back(w);
        end
        place_program(prog);
        foreach (prog[k])
        begin
            advance_one(w, pc);
            check_decoded(w, pc);
        end
        end_test();
    endtask

    task automatic test_pc_sequence();
        lc3b_word w;
        lc3b_word pc;
        start_test("pc sequence");
        for (int i = 0; i < 8; i++)
        begin
            advance_one(w, pc);
            check_word("id_pc", pc, id_pc);
        end
        end_test();
    endtask

    task automatic test_backpressure();
        lc3b_word w;
        lc3b_word pc;
        start_test("backpressure");
        advance_one(w, pc);
        // hold advance low over four responses
        while (resp_seen - resp_base < 4)
        begin
            check_bit("ready follows response", resp_seen != resp_base, ready);
            check_decoded(w, pc);
            check_word("held address", pc + lc3b_word'(2), imem_addr);
            @(negedge clk);
        end
        check_bit("ready held", 1'b1, ready);
        check_decoded(w, pc);
        // word stored again and again under the hold still decodes right
        advance_one(w, pc);
        check_decoded(w, pc);
        end_test();
    endtask

    initial
    begin
        clk        = 1'b0;
        arst_n     = 1'b0;
        advance    = 1'b0;
        imem_rdata = '0;
        imem_resp  = 1'b0;
        wb_we      = 1'b0;
        wb_dest    = '0;
        wb_data    = '0;
        seed       = 32'h2b6a_36a8;
        mem_wait   = 0;
        exp_pc     = `LC3B_RESET_PC;
        for (int i = 0; i < 256; i++)
            mem[i] = lc3b_word'($random(seed));
        for (int r = 0; r < `LC3B_NUM_REGS; r++)
            reg_model[r] = '0;
        test_reset();
        test_regfile();
        test_fields();
        test_decode();
        test_pc_sequence();
        test_backpressure();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule : lc3b_front_end_tb

/* logic/lc3b_front_end.sv */
`timescale 1ns/1ps

module lc3b_front_end
(
    input  logic                         clk,
    input  logic                         arst_n,
    // instruction memory
    output lc3b_types::lc3b_word         imem_addr,
    output logic                         imem_read,
    input  lc3b_types::lc3b_word         imem_rdata,
    input  logic                         imem_resp,
    // back end handshake
    input  logic                         advance,
    output logic                         ready,
    // decoded instruction
    output lc3b_types::lc3b_word         id_pc,
    output lc3b_types::lc3b_control_word id_ctrl,
    output lc3b_types::lc3b_reg          id_dest,
    output lc3b_types::lc3b_word         id_imm5,
    output lc3b_types::lc3b_word         id_offset6,
    output lc3b_types::lc3b_word         id_offset9,
    output lc3b_types::lc3b_offset11     id_offset11,
    output lc3b_types::lc3b_word         sr1_data,
    output lc3b_types::lc3b_word         sr2_data,
    // register write from writeback
    input  logic                         wb_we,
    input  lc3b_types::lc3b_reg          wb_dest,
    input  lc3b_types::lc3b_word         wb_data
);

    import lc3b_types::*;

    // fetch outputs
    lc3b_word         fetch_pc;
    lc3b_word         fetch_instr;
    // decode ahead of the boundary
    lc3b_control_word rom_ctrl;
    lc3b_word         rom_offset6;
    lc3b_word         rom_offset9;

    lc3b_id_if id_bus ();

    lc3b_fetch u_fetch (
        .clk      (clk),
        .arst_n   (arst_n),
        .advance  (advance),
        .mem_resp (imem_resp),
        .rdata    (imem_rdata),
        .pc       (fetch_pc),
        .instr    (fetch_instr)
    );

    lc3b_control_rom u_control_rom (
        .instr   (fetch_instr),
        .ctrl    (rom_ctrl),
        .offset6 (rom_offset6),
        .offset9 (rom_offset9)
    );

    ifid u_ifid (
        .clk          (clk),
        .arst_n       (arst_n),
        .advance      (advance),
        .mem_resp     (imem_resp),
        .instr        (fetch_instr),
        .pc_in        (fetch_pc),
        .ctrl_word_in (rom_ctrl),
        .offset6_in   (rom_offset6),
        .offset9_in   (rom_offset9),
        .mem_request  (imem_read),
        .ready        (ready),
        .id           (id_bus.stage)
    );

    lc3b_regfile u_regfile (
        .clk      (clk),
        .arst_n   (arst_n),
        .we       (wb_we),
        .dest     (wb_dest),
        .wdata    (wb_data),
        .id       (id_bus.reader),
        .sr1_data (sr1_data),
        .sr2_data (sr2_data)
    );

    // pc is the fetch address
    assign imem_addr   = fetch_pc;

    // remaining IF/ID fields straight to the back end
    assign id_pc       = id_bus.pc;
    assign id_ctrl     = id_bus.ctrl;
    assign id_dest     = id_bus.dest;
    assign id_imm5     = id_bus.imm5;
    assign id_offset6  = id_bus.offset6;
    assign id_offset9  = id_bus.offset9;
    assign id_offset11 = id_bus.offset11;

endmodule : lc3b_front_end

/* logic/lc3b_regfile.sv */
`timescale 1ns/1ps
`include "lc3b_cfg.svh"

module lc3b_regfile
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 we,
    input  lc3b_types::lc3b_reg  dest,
    input  lc3b_types::lc3b_word wdata,
    lc3b_id_if.reader            id,
    output lc3b_types::lc3b_word sr1_data,
    output lc3b_types::lc3b_word sr2_data
);

    import lc3b_types::*;

    // r0 through r7
    lc3b_word regs [`LC3B_NUM_REGS];

    // single write port from the back end
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            regs <= '{default: '0};
        end
        else if (we)
        begin
            regs[dest] <= wdata;
        end
    end

    // reads off the latched IF/ID indices
    // no write bypass, new data shows one cycle after the write edge
    assign sr1_data = regs[id.src1];
    assign sr2_data = regs[id.src2];

endmodule : lc3b_regfile

/* logic/ifid.sv */
`timescale 1ns/1ps

module ifid
(
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         advance,
    input  logic                         mem_resp,
    input  lc3b_types::lc3b_instr        instr,
    input  lc3b_types::lc3b_word         pc_in,
    input  lc3b_types::lc3b_control_word ctrl_word_in,
    input  lc3b_types::lc3b_word         offset6_in,
    input  lc3b_types::lc3b_word         offset9_in,
    output logic                         mem_request,
    output logic                         ready,
    lc3b_id_if.stage                     id
);

    import lc3b_types::*;

    // request and ready handshake with fetch memory
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            mem_request <= 1'b0;
            ready       <= 1'b0;
        end
        else if (advance)
        begin
            // one idle cycle while the pc steps
            // also keeps a held advance from taking the same word twice
            mem_request <= 1'b0;
            ready       <= 1'b0;
        end
        else
        begin
            mem_request <= 1'b1;
            // sticky once a response has arrived
            if (mem_resp)
            begin
                ready <= 1'b1;
            end
        end
    end

    // decoded fields, only touched on advance
    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            id.pc      <= pc_in;
            id.ctrl    <= ctrl_word_in;
            id.offset6 <= offset6_in;
            id.offset9 <= offset9_in;
            // register indices, bits 11:9, 8:6 and 2:0
            id.dest    <= instr.opr.dr;
            id.src1    <= instr.opr.sr1;
            id.src2    <= instr.opr.imm5[2:0];
            // bits 10:0 via the jsr layout
            id.offset11 <= instr.jsr.offset11;
            // imm5 widened with its sign
            id.imm5    <= lc3b_word'(signed'(instr.opr.imm5));
        end
    end

endmodule : ifid

/* logic/lc3b_control_rom.sv */
`timescale 1ns/1ps

module lc3b_control_rom
(
    input  lc3b_types::lc3b_instr        instr,
    output lc3b_types::lc3b_control_word ctrl,
    output lc3b_types::lc3b_word         offset6,
    output lc3b_types::lc3b_word         offset9
);

    import lc3b_types::*;

    // offsets through their own views of the word
    assign offset6 = lc3b_word'(signed'(instr.mem.offset6));
    assign offset9 = lc3b_word'(signed'(instr.br.offset9));

    always_comb
    begin
        // defaults: no loads, no memory, pass-through alu
        ctrl        = '0;
        ctrl.opcode = instr.opr.opcode;
        ctrl.aluop  = alu_pass;

        unique case (instr.opr.opcode)
            op_add:
            begin
                ctrl.aluop        = alu_add;
                ctrl.load_regfile = 1'b1;
                ctrl.sr2_sel      = instr.opr.imm_flag;
            end
            op_and:
            begin
                ctrl.aluop        = alu_and;
                ctrl.load_regfile = 1'b1;
                ctrl.sr2_sel      = instr.opr.imm_flag;
            end
            op_not:
            begin
                ctrl.aluop        = alu_not;
                ctrl.load_regfile = 1'b1;
            end
            op_shf:
            begin
                // bit 4 picks direction, bit 5 arithmetic vs logical
                ctrl.load_regfile = 1'b1;
                if (!instr.opr.imm5[4])
                    ctrl.aluop = alu_sll;
                else if (instr.opr.imm_flag)
                    ctrl.aluop = alu_sra;
                else
                    ctrl.aluop = alu_srl;
            end
            op_lea:
            begin
                // address formed outside the alu
                ctrl.load_regfile = 1'b1;
            end
            op_ldb, op_ldi, op_ldr:
            begin
                // base plus offset address
                ctrl.aluop        = alu_add;
                ctrl.load_regfile = 1'b1;
                ctrl.mem_read     = 1'b1;
            end
            op_stb, op_sti, op_str:
            begin
                ctrl.aluop     = alu_add;
                ctrl.mem_write = 1'b1;
            end
            op_br, op_jmp:
            begin
                ctrl.branch = 1'b1;
            end
            op_jsr:
            begin
                ctrl.jsr_link = 1'b1;
            end
            // rti, trap: defaults only
            default:
            begin
                ctrl.aluop = alu_pass;
            end
        endcase
    end

endmodule : lc3b_control_rom

/* logic/lc3b_fetch.sv */
`timescale 1ns/1ps
`include "lc3b_cfg.svh"

module lc3b_fetch
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 advance,
    input  logic                 mem_resp,
    input  lc3b_types::lc3b_word rdata,
    output lc3b_types::lc3b_word pc,
    output lc3b_types::lc3b_word instr
);

    import lc3b_types::*;

    // next sequential address
    lc3b_word pc_plus2;

    // buffer load strobe
    logic     instr_load;

    // byte addressed, one instruction is two bytes
    assign pc_plus2 = pc + lc3b_word'(2);

    // advance wins over a response in the same cycle
    // the word at the old pc is already in the buffer by then
    assign instr_load = mem_resp && !advance;

    // program counter
    // also serves directly as the instruction memory address
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pc <= `LC3B_RESET_PC;
        end
        else if (advance)
        begin
            // step once per instruction handed to IF/ID
            pc <= pc_plus2;
        end
    end

    // fetched instruction buffer
    // repeated responses under back-pressure rewrite the same word
    always_ff @(posedge clk)
    begin
        if (instr_load)
        begin
            instr <= rdata;
        end
    end

    // The buffer feeds the control ROM and ifid in parallel, so the word
    // decoded here is the one latched on the next advance.

endmodule : lc3b_fetch

/* logic/lc3b_id_if.sv */
`timescale 1ns/1ps

interface lc3b_id_if;

    import lc3b_types::*;

    // decoded instruction as held in the IF/ID register
    lc3b_word         pc;
    lc3b_control_word ctrl;
    lc3b_reg          dest;
    lc3b_reg          src1;
    lc3b_reg          src2;
    // sign-extended immediates
    lc3b_word         imm5;
    lc3b_word         offset6;
    lc3b_word         offset9;
    // jsr field, extension happens downstream
    lc3b_offset11     offset11;

    // pipeline register side, owns every field
    modport stage (
        output pc, ctrl, dest, src1, src2, imm5, offset6, offset9, offset11
    );

    // register file only needs the two source indices
    modport reader (
        input src1, src2
    );

endinterface : lc3b_id_if

/* logic/lc3b_types.sv */
`include "lc3b_cfg.svh"

package lc3b_types;

    // one machine word, data or byte address
    typedef logic [`LC3B_WORD_W-1:0] lc3b_word;

    // register index
    typedef logic [$clog2(`LC3B_NUM_REGS)-1:0] lc3b_reg;

    // raw jsr displacement, left unextended
    typedef logic [10:0] lc3b_offset11;

    // lc3b opcode map, bits 15:12
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    // alu function for the execute stage
    typedef enum logic [2:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass,
        alu_sll,
        alu_srl,
        alu_sra
    } lc3b_aluop;

    // per-instruction control, carried down the pipe
    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_aluop  aluop;
        logic       load_regfile;
        logic       mem_read;
        logic       mem_write;
        // 1 selects imm5, 0 selects sr2
        logic       sr2_sel;
        logic       branch;
        logic       jsr_link;
    } lc3b_control_word;

    // one instruction word, four field layouts
    typedef union packed {
        // operate format: add, and, not, shf
        struct packed {
            lc3b_opcode opcode;
            lc3b_reg    dr;
            lc3b_reg    sr1;
            logic       imm_flag;
            logic [4:0] imm5;
        } opr;
        // base plus offset6 loads and stores
        struct packed {
            lc3b_opcode opcode;
            lc3b_reg    dr_sr;
            lc3b_reg    base;
            logic [5:0] offset6;
        } mem;
        // pc relative branch, lea
        struct packed {
            lc3b_opcode opcode;
            logic [2:0] nzp;
            logic [8:0] offset9;
        } br;
        // jsr with long displacement
        struct packed {
            lc3b_opcode   opcode;
            logic         link;
            lc3b_offset11 offset11;
        } jsr;
    } lc3b_instr;

endpackage : lc3b_types

/* include/lc3b_cfg.svh */
`ifndef LC3B_CFG_SVH
`define LC3B_CFG_SVH

// machine word, shared by instructions, data and addresses
`define LC3B_WORD_W 16

// architectural register count
// register index width is derived from this in the types package
`define LC3B_NUM_REGS 8

// first fetch address out of reset
// word aligned, fetch steps by 2 bytes
`define LC3B_RESET_PC 16'h0000

`endif
